// File: Bender.yml
package:
  name: fgen

sources:
  - include_dirs:
      - .
    files:
      - fgen_pkg.sv
      - spi_txn_if.sv
      - spi_peripheral.sv
      - control_registers.sv
      - waveform_memory.sv
      - playback_sequencer.sv
      - fgen_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - fgen_tb.sv

// File: control_registers.sv
// ----------------------------
// register file behind chip select 0
// reg 0 start byte address, reg 1 end byte address, 2 and 3 scratch
// ----------------------------
`timescale 1ns/1ps
`include "fgen_config.svh"

module control_registers import fgen_pkg::*; (
	input logic word_clock,
	input logic reset3_word_clock,
	spi_txn_if.target txn,
	output logic [`FGEN_MEM_BYTE_AW-1:0] start_addr,
	output logic [`FGEN_MEM_BYTE_AW-1:0] end_addr
);

	data_word_u regs [`FGEN_NUM_REGS];
	data_word_u rdata_q;
	logic [`FGEN_REG_AW-1:0] reg_idx;
	logic write_en;

	// upper address bits alias onto the four registers
	assign reg_idx = txn.frame.addr[`FGEN_REG_AW-1:0];
	assign write_en = txn.valid && (txn.frame.cmd == `FGEN_CMD_WRITE);

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			for (int i = 0; i < `FGEN_NUM_REGS; i++) begin
				regs[i].word <= '0;
			end
		end else if (write_en) begin
			regs[reg_idx].word <= txn.frame.data.word;
		end
	end

	// read word fetched once per frame, held for the data phase
	always_ff @(posedge word_clock) begin
		if (txn.load_addr) begin
			rdata_q.word <= regs[reg_idx].word;
		end
	end

	assign txn.rdata = rdata_q;

	// ----------------------------
	// playback window
	// ----------------------------
	assign start_addr = regs[0].word[`FGEN_MEM_BYTE_AW-1:0];
	assign end_addr = regs[1].word[`FGEN_MEM_BYTE_AW-1:0];

endmodule

// File: fgen_config.svh
// ----------------------------
// sizes and SPI frame constants for the function generator
// include wherever a width or depth is needed
// ----------------------------
`ifndef FGEN_CONFIG_SVH
`define FGEN_CONFIG_SVH

// waveform memory, 32-bit words on the SPI side
`define FGEN_MEM_WORDS 256
`define FGEN_MEM_WORD_AW 8

// same storage seen as bytes on the playback side
`define FGEN_MEM_BYTE_AW 10

// control register file on chip select 0
`define FGEN_NUM_REGS 4
`define FGEN_REG_AW 2

// command8 value that writes, anything else is a plain read
`define FGEN_CMD_WRITE 8'h01

// command8 + address16 + data32
`define FGEN_FRAME_BITS 56

`endif

// File: fgen_pkg.sv
// ----------------------------
// types shared by the SPI peripherals and their targets
// ----------------------------
package fgen_pkg;

	typedef logic [7:0] cmd_t;
	typedef logic [15:0] addr_t;

	// ----------------------------
	// data word, two decodings
	// ----------------------------
	// word view for the register file
	// byte view for the waveform memory, bytes[0] is bits 31:24
	// and is the first byte on the wire
	typedef union packed {
		logic [31:0] word;
		logic [0:3][7:0] bytes;
	} data_word_u;

	// ----------------------------
	// one SPI frame, in wire order
	// ----------------------------
	// cmd is shifted in first, so it sits in the top bits
	typedef struct packed {
		cmd_t cmd;
		addr_t addr;
		data_word_u data;
	} spi_frame_t;

endpackage

// File: fgen_tb.sv
// ----------------------------
// testbench for the function generator, plays the SPI trace as host
// checks read-back words and the byte stream between sync pulses
// ----------------------------
`timescale 1ns/1ps
`include "fgen_config.svh"

module fgen_tb;

	localparam int HALF = 4;
	localparam int FRAME_CYCLES = `FGEN_FRAME_BITS * 2 * HALF + 40;

	logic word_clock;
	logic reset3_word_clock;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_ce0;
	logic spi_ce1;
	logic spi_miso;
	logic [7:0] word_out;
	logic sync_out;

	integer seed = 83;
	int mismatch_count = 0;
	int other_count = 0;
	int watchdog_cycles = 0;

	// trace columns, one entry per line
	byte kind_q[$];
	logic [31:0] col_a[$];
	logic [31:0] col_b[$];
	logic [31:0] col_c[$];
	int col_d[$];

	// what the host believes the waveform memory holds
	logic [31:0] shadow_mem [`FGEN_MEM_WORDS];

	tb_clock_gen clk_gen (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock)
	);

	fgen_top DUT (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.spi_sclk(spi_sclk),
		.spi_mosi(spi_mosi),
		.spi_ce0(spi_ce0),
		.spi_ce1(spi_ce1),
		.spi_miso(spi_miso),
		.word_out(word_out),
		.sync_out(sync_out)
	);

	// big endian, byte 4a+k is bits 31-8k of word a
	function automatic logic [7:0] shadow_byte(input int b);
		logic [31:0] w;
		w = shadow_mem[b / 4];
		return w[31 - 8 * (b % 4) -: 8];
	endfunction

	// ----------------------------
	// SPI host, mode 0
	// ----------------------------
	// stops after nbits rising edges, data phase from MISO lands in rd
	task automatic spi_frame(input logic cs, input logic [7:0] cmd, input logic [15:0] addr,
			input logic [31:0] data, input int nbits, output logic [31:0] rd);
		logic [55:0] bits;
		bits = {cmd, addr, data};
		rd = '0;
		@(posedge word_clock);
		spi_ce0 <= cs;
		spi_ce1 <= ~cs;
		for (int i = 0; i < nbits; i++) begin
			spi_mosi <= bits[55 - i];
			repeat (HALF) @(posedge word_clock);
			spi_sclk <= 1'b1;
			if (i >= 24) begin
				rd = {rd[30:0], spi_miso};
			end
			repeat (HALF) @(posedge word_clock);
			spi_sclk <= 1'b0;
		end
		repeat (HALF) @(posedge word_clock);
		spi_ce0 <= 1'b1;
		spi_ce1 <= 1'b1;
		// idle gap, long enough for the strobe and the write to land
		repeat (8 + ($unsigned($random(seed)) % 8)) @(posedge word_clock);
	endtask

	task automatic read_check(input logic cs, input logic [15:0] addr, input logic [31:0] exp);
		logic [31:0] got;
		spi_frame(cs, 8'h00, addr, 32'h0, `FGEN_FRAME_BITS, got);
		assert (got === exp) else begin
			mismatch_count++;
			$display("mismatch at %0t: cs%0d addr %h read %h, expected %h",
				$time, cs, addr, got, exp);
		end
	endtask

	// ----------------------------
	// playback window check
	// ----------------------------
	task automatic check_playback(input int start, input int stop, input int passes);
		int len;
		logic [7:0] exp;
		len = (stop > start) ? stop - start : 1;
		while (sync_out !== 1'b1) begin
			@(posedge word_clock);
		end
		for (int p = 0; p < passes; p++) begin
			for (int k = 0; k < len; k++) begin
				if (p != 0 || k != 0) begin
					@(posedge word_clock);
				end
				exp = shadow_byte(start + k);
				assert (sync_out === (k == 0)) else begin
					mismatch_count++;
					$display("mismatch at %0t: sync %b at byte %0d of pass %0d",
						$time, sync_out, k, p);
				end
				assert (word_out === exp) else begin
					mismatch_count++;
					$display("mismatch at %0t: byte %0d of pass %0d is %h, expected %h",
						$time, start + k, p, word_out, exp);
				end
			end
		end
		@(posedge word_clock);
		assert (sync_out === 1'b1) else begin
			mismatch_count++;
			$display("mismatch at %0t: no sync after window %0d..%0d", $time, start, stop);
		end
	endtask

	// ----------------------------
	// main sequence
	// ----------------------------
	initial begin
		int fd;
		int code;
		int ch;
		byte kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		int d;
		int worst;
		int len;
		logic [31:0] rd;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_ce0 = 1'b1;
		spi_ce1 = 1'b1;
		worst = FRAME_CYCLES;
		fd = $fopen("fgen_trace.txt", "r");
		assert (fd != 0) else begin
			other_count++;
			$display("could not open the trace file fgen_trace.txt");
		end
		if (fd != 0) begin
			code = $fscanf(fd, " %c", kind);
			while (code == 1) begin
				if (kind == "#") begin
					ch = $fgetc(fd);
					while (ch != "\n" && ch != -1) begin
						ch = $fgetc(fd);
					end
				end else begin
					d = 0;
					code = $fscanf(fd, "%h %h %h", a, b, c);
					if (kind == "T") begin
						code = $fscanf(fd, "%d", d);
					end
					kind_q.push_back(kind);
					col_a.push_back(a);
					col_b.push_back(b);
					col_c.push_back(c);
					col_d.push_back(d);
					// playback may first have to drain a whole old window
					len = (b > a) ? b - a : 1;
					if (kind == "P" && (c + 2) * len + 2048 > worst) begin
						worst = (c + 2) * len + 2048;
					end
				end
				code = $fscanf(fd, " %c", kind);
			end
			$fclose(fd);
		end
		watchdog_cycles = (kind_q.size() + 1) * worst + 200;

		wait (!reset3_word_clock);
		@(posedge word_clock);
		assert (sync_out === 1'b0 && spi_miso === 1'b0) else begin
			mismatch_count++;
			$display("mismatch at %0t: after reset sync %b miso %b, expected 0 0",
				$time, sync_out, spi_miso);
		end

		for (int i = 0; i < kind_q.size(); i++) begin
			case (kind_q[i])
				"W": begin
					spi_frame(col_a[i][0], `FGEN_CMD_WRITE, col_b[i][15:0], col_c[i],
						`FGEN_FRAME_BITS, rd);
					if (col_a[i][0]) begin
						shadow_mem[col_b[i][`FGEN_MEM_WORD_AW-1:0]] = col_c[i];
					end
				end
				"R": read_check(col_a[i][0], col_b[i][15:0], col_c[i]);
				// cut short, memory must keep its old word
				"T": spi_frame(col_a[i][0], `FGEN_CMD_WRITE, col_b[i][15:0], col_c[i],
					col_d[i], rd);
				"P": check_playback(col_a[i], col_b[i], col_c[i]);
				default: begin
					other_count++;
					$display("unknown trace line kind %c at entry %0d", kind_q[i], i);
				end
			endcase
		end

		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// ----------------------------
	// watchdog
	// ----------------------------
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge word_clock);
		other_count++;
		$display("timeout after %0d cycles, the trace did not finish", watchdog_cycles);
		$display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
		$display("Test failed");
		$finish;
	end

endmodule

// File: fgen_top.sv
// ----------------------------
// function generator top, two SPI chip selects sharing SCK and MOSI
// cs0 reaches the control registers, cs1 the waveform memory
// ----------------------------
`timescale 1ns/1ps
`include "fgen_config.svh"

module fgen_top (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic spi_sclk,
	input logic spi_mosi,
	input logic spi_ce0,
	input logic spi_ce1,
	output logic spi_miso,
	output logic [7:0] word_out,
	output logic sync_out
);

	logic miso_ce0;
	logic miso_ce1;
	logic [`FGEN_MEM_BYTE_AW-1:0] start_addr;
	logic [`FGEN_MEM_BYTE_AW-1:0] end_addr;
	logic [`FGEN_MEM_BYTE_AW-1:0] byte_addr;

	spi_txn_if txn_regs ();
	spi_txn_if txn_mem ();

	// ----------------------------
	// chip select 0, registers
	// ----------------------------
	spi_peripheral spi_ce0_peripheral (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.sck(spi_sclk),
		.mosi(spi_mosi),
		.ssel(spi_ce0),
		.miso(miso_ce0),
		.txn(txn_regs.peripheral)
	);

	control_registers regs (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.txn(txn_regs.target),
		.start_addr(start_addr),
		.end_addr(end_addr)
	);

	// ----------------------------
	// chip select 1, waveform
	// ----------------------------
	spi_peripheral spi_ce1_peripheral (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.sck(spi_sclk),
		.mosi(spi_mosi),
		.ssel(spi_ce1),
		.miso(miso_ce1),
		.txn(txn_mem.peripheral)
	);

	waveform_memory mem (
		.word_clock(word_clock),
		.txn(txn_mem.target),
		.byte_addr(byte_addr),
		.byte_out(word_out)
	);

	playback_sequencer seq (
		.word_clock(word_clock),
		.reset3_word_clock(reset3_word_clock),
		.start_addr(start_addr),
		.end_addr(end_addr),
		.byte_addr(byte_addr),
		.sync(sync_out)
	);

	// cs1 only when it alone is selected, otherwise peripheral 0
	assign spi_miso = (spi_ce0 && !spi_ce1) ? miso_ce1 : miso_ce0;

endmodule

// File: fgen_trace.txt
# W/R/T: chip select, word address, data or expected read word; T adds bits sent before deselect
# P: window start, window end, passes to check on word_out
R 0 0000 00000000
R 0 0001 00000000
W 1 0000 a1b2c3d4
P 000 000 4
W 0 0002 cafef00d
W 0 0003 12345678
R 0 0002 cafef00d
R 0 0003 12345678
W 1 0001 00112233
W 1 0002 44556677
W 1 0003 8899aabb
R 1 0001 00112233
R 1 0003 8899aabb
T 1 0002 deadbeef 40
R 1 0002 44556677
W 0 0000 00000005
W 0 0001 0000000e
R 0 0001 0000000e
P 005 00e 3
W 0 0000 00000002
P 002 00e 2

// File: flist.f
+incdir+.
fgen_pkg.sv
spi_txn_if.sv
spi_peripheral.sv
control_registers.sv
waveform_memory.sv
playback_sequencer.sv
fgen_top.sv
tb_clock_gen.sv
fgen_tb.sv

// File: playback_sequencer.sv
// ----------------------------
// byte address counter for playback
// wraps from end-1 back to start, sync marks the first byte of a pass
// ----------------------------
`timescale 1ns/1ps
`include "fgen_config.svh"

module playback_sequencer (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic [`FGEN_MEM_BYTE_AW-1:0] start_addr,
	input logic [`FGEN_MEM_BYTE_AW-1:0] end_addr,
	output logic [`FGEN_MEM_BYTE_AW-1:0] byte_addr,
	output logic sync
);

	logic [`FGEN_MEM_BYTE_AW-1:0] live_last;
	logic [`FGEN_MEM_BYTE_AW-1:0] win_start;
	logic [`FGEN_MEM_BYTE_AW-1:0] win_last;
	logic out_of_window;
	logic reload;
	logic wrap_q;
	logic sync_q;

	// empty or inverted window collapses to the single byte at start
	assign live_last = (end_addr > start_addr) ? end_addr - 1'b1 : start_addr;
	assign out_of_window = (byte_addr < start_addr) || (byte_addr > live_last);
	assign reload = (byte_addr == win_last) || out_of_window;

	// ----------------------------
	// address counter
	// ----------------------------
	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			byte_addr <= start_addr;
			win_start <= start_addr;
			win_last <= live_last;
			// first pass after reset gets its sync too
			wrap_q <= 1'b1;
			sync_q <= 1'b0;
		end else begin
			// one stage, matches the memory read latency
			sync_q <= wrap_q;
			if (reload) begin
				byte_addr <= start_addr;
				win_start <= start_addr;
				win_last <= live_last;
				wrap_q <= 1'b1;
			end else begin
				byte_addr <= byte_addr + 1'b1;
				wrap_q <= 1'b0;
			end
		end
	end

	assign sync = sync_q;

	a_addr_in_window: assert property (
		@(posedge word_clock) disable iff (reset3_word_clock)
		(byte_addr >= win_start) && (byte_addr <= win_last)
	) else $error("playback address %0d left window", byte_addr);

endmodule

// File: spi_peripheral.sv
// ----------------------------
// SPI mode 0 slave oversampled in word_clock
// command8/address16/data32 frames MSB first with the read word on MISO
// ----------------------------
`timescale 1ns/1ps
`include "fgen_config.svh"

module spi_peripheral import fgen_pkg::*; (
	input logic word_clock,
	input logic reset3_word_clock,
	input logic sck,
	input logic mosi,
	input logic ssel,
	output logic miso,
	spi_txn_if.peripheral txn
);

	localparam int HDR_BITS = $bits(cmd_t) + $bits(addr_t);
	// one spare bit so an overlong frame cannot wrap back to 56
	localparam int COUNT_W = $clog2(`FGEN_FRAME_BITS + 1) + 1;

	// ----------------------------
	// synchronizers and edge detect
	// ----------------------------
	logic [2:0] sck_sync;
	logic [2:0] ssel_sync;
	logic [1:0] mosi_sync;
	logic sck_rise;
	logic sck_fall;
	logic ssel_rise;
	logic selected;
	logic mosi_bit;

	// shift registers and the captured header
	logic [31:0] rx_shift;
	logic [31:0] tx_shift;
	cmd_t cmd_q;
	addr_t addr_q;

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			sck_sync <= '0;
			ssel_sync <= '1;
			mosi_sync <= '0;
		end else begin
			sck_sync <= {sck_sync[1:0], sck};
			ssel_sync <= {ssel_sync[1:0], ssel};
			mosi_sync <= {mosi_sync[0], mosi};
		end
	end

	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign sck_fall = ~sck_sync[1] & sck_sync[2];
	assign ssel_rise = ssel_sync[1] & ~ssel_sync[2];
	assign selected = ~ssel_sync[1];
	assign mosi_bit = mosi_sync[1];

	// ----------------------------
	// bit count and strobes
	// ----------------------------
	logic [COUNT_W-1:0] bit_count;
	logic load_addr_q;
	logic load_d;
	logic valid_q;

	always_ff @(posedge word_clock) begin
		if (reset3_word_clock) begin
			bit_count <= '0;
			load_addr_q <= 1'b0;
			load_d <= 1'b0;
			valid_q <= 1'b0;
			miso <= 1'b0;
		end else begin
			load_addr_q <= 1'b0;
			load_d <= load_addr_q;
			// short or long frames are dropped here
			valid_q <= ssel_rise && (bit_count == COUNT_W'(`FGEN_FRAME_BITS));
			if (!selected) begin
				bit_count <= '0;
				miso <= 1'b0;
			end else begin
				if (sck_rise) begin
					if (bit_count != '1) begin
						bit_count <= bit_count + 1'b1;
					end
					if (bit_count == COUNT_W'(HDR_BITS - 1)) begin
						load_addr_q <= 1'b1;
					end
				end
				// host samples this on the next rising edge
				if (sck_fall) begin
					miso <= tx_shift[31];
				end
			end
		end
	end

	// ----------------------------
	// shift registers
	// ----------------------------
	always_ff @(posedge word_clock) begin
		if (selected && sck_rise) begin
			rx_shift <= {rx_shift[30:0], mosi_bit};
			// header captured as the 24th bit arrives
			if (bit_count == COUNT_W'(HDR_BITS - 1)) begin
				{cmd_q, addr_q} <= {rx_shift[HDR_BITS-2:0], mosi_bit};
			end
		end
		if (!selected) begin
			tx_shift <= '0;
		end else if (load_d) begin
			tx_shift <= txn.rdata;
		end else if (sck_fall) begin
			tx_shift <= {tx_shift[30:0], 1'b0};
		end
	end

	// last 32 bits in rx_shift are the data phase
	assign txn.frame = {cmd_q, addr_q, rx_shift};
	assign txn.valid = valid_q;
	assign txn.load_addr = load_addr_q;

	// strobe lands 3 cycles after deselect so the host waits that long before reselecting
	a_valid_while_deselected: assert property (
		@(posedge word_clock) disable iff (reset3_word_clock)
		txn.valid |-> ssel
	) else $error("spi valid while chip select is low");

endmodule

// File: spi_txn_if.sv
// ----------------------------
// one decoded SPI transaction plus the word shifted back out
// peripheral drives the frame, target answers with rdata
// ----------------------------
`timescale 1ns/1ps

interface spi_txn_if import fgen_pkg::*; ();

	// single-cycle strobe, frame complete and 56 bits long
	logic valid;
	spi_frame_t frame;

	// cmd and addr are in, target should fetch read data now
	logic load_addr;

	// must be ready the cycle after load_addr
	// and stay put until valid
	data_word_u rdata;

	modport peripheral (
		output valid,
		output frame,
		output load_addr,
		input rdata
	);

	modport target (
		input valid,
		input frame,
		input load_addr,
		output rdata
	);

endinterface

// File: tb_clock_gen.sv
// ----------------------------
// testbench clock, 20 ns period
// reset held high for the first 10 rising edges
// ----------------------------
`timescale 1ns/1ps

module tb_clock_gen (
	output logic word_clock,
	output logic reset3_word_clock
);

	initial begin
		word_clock = 1'b0;
		forever begin
			#10 word_clock = ~word_clock;
		end
	end

	initial begin
		reset3_word_clock = 1'b1;
		repeat (10) @(posedge word_clock);
		reset3_word_clock <= 1'b0;
	end

endmodule

// File: waveform_memory.sv
// ----------------------------
// waveform storage, 32-bit words on the SPI side
// 8-bit registered read for playback, byte 4a+k is byte k of word a
// ----------------------------
`timescale 1ns/1ps
`include "fgen_config.svh"

module waveform_memory import fgen_pkg::*; (
	input logic word_clock,
	spi_txn_if.target txn,
	input logic [`FGEN_MEM_BYTE_AW-1:0] byte_addr,
	output logic [7:0] byte_out
);

	// ----------------------------
	// storage
	// ----------------------------
	data_word_u mem [`FGEN_MEM_WORDS];

	logic [`FGEN_MEM_WORD_AW-1:0] spi_word_addr;
	logic [`FGEN_MEM_WORD_AW-1:0] play_word_addr;
	logic [1:0] play_lane;
	logic write_en;
	data_word_u rdata_q;

	assign spi_word_addr = txn.frame.addr[`FGEN_MEM_WORD_AW-1:0];
	assign write_en = txn.valid && (txn.frame.cmd == `FGEN_CMD_WRITE);

	// ----------------------------
	// SPI port, whole words
	// ----------------------------
	always_ff @(posedge word_clock) begin
		if (write_en) begin
			mem[spi_word_addr].bytes <= txn.frame.data.bytes;
		end
		// read for this frame's data phase
		if (txn.load_addr) begin
			rdata_q.bytes <= mem[spi_word_addr].bytes;
		end
	end

	assign txn.rdata = rdata_q;

	// ----------------------------
	// playback port, one byte
	// ----------------------------
	assign play_word_addr = byte_addr[`FGEN_MEM_BYTE_AW-1:2];
	assign play_lane = byte_addr[1:0];

	// big endian within the word, lane 0 is the top byte
	always_ff @(posedge word_clock) begin
		byte_out <= mem[play_word_addr].bytes[play_lane];
	end

	a_addr_in_range: assert property (
		@(posedge word_clock)
		txn.valid |-> (txn.frame.addr < `FGEN_MEM_WORDS)
	) else $error("waveform address %0d beyond memory", txn.frame.addr);

endmodule
